// File: Bender.yml
package:
  name: frv_core_fetch

sources:
  # Packages first, then the fetch unit from the leaves up
  - files:
      - design/frv_core_pkg.sv
      - design/frv_instr_pkg.sv
      - design/frv_fetch_ctrl.sv
      - design/frv_core_fetch_buffer.sv
      - design/frv_fetch_predecode.sv
      - design/frv_core_fetch.sv

  # Simulation only
  - target: test
    files:
      - testbench/frv_fetch_checker.sv
      - testbench/frv_fetch_tb.sv

// File: design/frv_core_fetch.sv
`timescale 1ns/1ps
module frv_core_fetch #(
    parameter int                            BWIDTH   = 80,   // 64, 80 or 96
    parameter logic [frv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          cf_valid,
    input  logic [frv_core_pkg::XLEN-1:0] cf_target,
    output logic                          mem_req,
    output logic [frv_core_pkg::XLEN-1:0] mem_addr,
    input  logic                          mem_gnt,
    input  logic                          mem_rvalid,
    input  logic [frv_core_pkg::XLEN-1:0] mem_rdata,
    input  logic                          mem_err,
    output logic                          instr_valid,
    output logic [frv_core_pkg::XLEN-1:0] instr_data,
    output logic [frv_core_pkg::XLEN-1:0] instr_pc,
    output logic                          instr_size4,
    output logic                          instr_err,
    output logic                          instr_cf,
    input  logic                          instr_ready
);

    localparam int XL = frv_core_pkg::XLEN;

    // Controller to buffer
    logic          flush;
    logic [XL-1:0] flush_pc;
    logic          f_4byte;
    logic          f_2byte;
    logic          f_err;
    logic [XL-1:0] f_in;
    logic          f_ready;

    // Buffer to predecoder
    logic [XL-1:0] buf_out;
    logic          buf_out_4;
    logic          buf_err;
    logic          buf_valid;

    frv_fetch_ctrl #(
        .RESET_PC (RESET_PC)
    ) u_ctrl (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_valid   (cf_valid),
        .cf_target  (cf_target),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_err    (mem_err),
        .f_ready    (f_ready),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .f_4byte    (f_4byte),
        .f_2byte    (f_2byte),
        .f_err      (f_err),
        .f_in       (f_in)
    );

    frv_core_fetch_buffer #(
        .BWIDTH (BWIDTH)
    ) u_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (flush),
        .f_4byte   (f_4byte),
        .f_2byte   (f_2byte),
        .f_err     (f_err),
        .f_in      (f_in),
        .f_ready   (f_ready),
        .buf_out   (buf_out),
        .buf_out_4 (buf_out_4),
        .buf_err   (buf_err),
        .buf_valid (buf_valid),
        .buf_ready (instr_ready)    // Same strobe eats from the buffer
    );

    frv_fetch_predecode #(
        .RESET_PC (RESET_PC)
    ) u_predecode (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .buf_out     (buf_out),
        .buf_out_4   (buf_out_4),
        .buf_valid   (buf_valid),
        .buf_err     (buf_err),
        .instr_ready (instr_ready),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_pc    (instr_pc),
        .instr_size4 (instr_size4),
        .instr_err   (instr_err),
        .instr_cf    (instr_cf)
    );

endmodule

// File: design/frv_core_fetch_buffer.sv
`timescale 1ns/1ps
module frv_core_fetch_buffer #(
    parameter int BWIDTH = 80
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          flush,      // Drop all contents
    input  logic                          f_4byte,    // Whole word in
    input  logic                          f_2byte,    // Upper halfword of f_in only
    input  logic                          f_err,
    input  logic [frv_core_pkg::XLEN-1:0] f_in,
    output logic                          f_ready,
    output logic [frv_core_pkg::XLEN-1:0] buf_out,
    output logic                          buf_out_4,
    output logic                          buf_err,
    output logic                          buf_valid,
    input  logic                          buf_ready   // Consumer takes the shown instruction
);

    localparam int XL  = frv_core_pkg::XLEN;
    localparam int HW  = frv_core_pkg::HW_BITS;
    localparam int HWS = frv_core_pkg::hw_count(BWIDTH);    // Halfword slots
    localparam int DW  = frv_core_pkg::depth_bits(HWS);

    logic [BWIDTH-1:0] buffer;      // Slot 0 in the low bits
    logic [BWIDTH-1:0] n_buffer;
    logic [BWIDTH-1:0] buf_in;
    logic [BWIDTH-1:0] buf_keep;
    logic [HWS-1:0]    hw_err;      // One error bit per slot
    logic [HWS-1:0]    n_hw_err;
    logic [HWS-1:0]    err_in;
    logic [HWS-1:0]    err_keep;
    logic [DW-1:0]     bdepth;      // Valid halfwords
    logic [DW-1:0]     n_bdepth;
    logic [DW-1:0]     insert_at;
    logic [DW-1:0]     depth_add;
    logic [DW-1:0]     depth_sub;
    logic [XL-1:0]     word_in;
    logic              is_32;
    logic              buf_out_2;
    logic              eat_2;
    logic              eat_4;
    logic              update;

    assign buf_out   = buffer[XL-1:0];
    assign is_32     = buf_out[1:0] == 2'b11;              // Length from the low bits

    // Lowest instruction is complete
    assign buf_out_2 = !is_32 && (bdepth >= DW'(1));
    assign buf_out_4 = is_32 && (bdepth >= DW'(2));
    assign buf_valid = buf_out_2 || buf_out_4;
    assign buf_err   = buf_out_4 ? |hw_err[1:0] : hw_err[0];

    assign eat_2     = buf_out_2 && buf_ready;
    assign eat_4     = buf_out_4 && buf_ready;

    assign depth_add = DW'({f_4byte, f_2byte});            // 2 or 1 halfwords in
    assign depth_sub = DW'({eat_4, eat_2});                // 2 or 1 halfwords out
    assign insert_at = bdepth - depth_sub;                 // First free slot after eating
    assign n_bdepth  = insert_at + depth_add;

    // Two free slots left once this cycle settles
    assign f_ready   = n_bdepth <= DW'(HWS - 2);

    assign word_in   = f_2byte ? {{HW{1'b0}}, f_in[XL-1:HW]} :
                       f_4byte ? f_in                        :
                                 '0;

    // Slots above the insert point are cleared, so old data never leaks in
    assign buf_in    = BWIDTH'(word_in) << (HW * insert_at);
    assign buf_keep  = ~({BWIDTH{1'b1}} << (HW * insert_at));
    assign n_buffer  = ((buffer >> (HW * depth_sub)) & buf_keep) | buf_in;

    assign err_in    = HWS'({f_4byte && f_err, (f_4byte || f_2byte) && f_err}) << insert_at;
    assign err_keep  = ~({HWS{1'b1}} << insert_at);
    assign n_hw_err  = ((hw_err >> depth_sub) & err_keep) | err_in;

    assign update    = f_4byte || f_2byte || eat_2 || eat_4;

    always_ff @(posedge g_clk) begin
        if (g_resetn || flush) begin
            bdepth <= '0;
        end else if (update) begin
            bdepth <= n_bdepth;
        end
    end

    // Contents are only trusted below bdepth
    always_ff @(posedge g_clk) begin
        if (update) begin
            buffer <= n_buffer;
            hw_err <= n_hw_err;
        end
    end

endmodule

// File: design/frv_core_pkg.sv
// Core-wide widths shared by the fetch unit
package frv_core_pkg;

    // Data and address width
    localparam int XLEN    = 32;

    // One halfword, the smallest instruction parcel
    localparam int HW_BITS = 16;

    // Halfwords that fit in a given number of bits
    function automatic int hw_count(input int bits);
        return bits / HW_BITS;
    endfunction

    // Counter width able to hold 0 up to hws halfwords
    function automatic int depth_bits(input int hws);
        return $clog2(hws + 1);
    endfunction

endpackage

// File: design/frv_fetch_ctrl.sv
`timescale 1ns/1ps
module frv_fetch_ctrl #(
    parameter logic [frv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          cf_valid,   // Redirect strobe
    input  logic [frv_core_pkg::XLEN-1:0] cf_target,  // Halfword aligned
    output logic                          mem_req,
    output logic [frv_core_pkg::XLEN-1:0] mem_addr,
    input  logic                          mem_gnt,
    input  logic                          mem_rvalid,
    input  logic [frv_core_pkg::XLEN-1:0] mem_rdata,
    input  logic                          mem_err,
    input  logic                          f_ready,    // Buffer has room for a word
    output logic                          flush,
    output logic [frv_core_pkg::XLEN-1:0] flush_pc,
    output logic                          f_4byte,
    output logic                          f_2byte,
    output logic                          f_err,
    output logic [frv_core_pkg::XLEN-1:0] f_in
);

    localparam int XL = frv_core_pkg::XLEN;

    logic [XL-1:0] fetch_addr;      // Word aligned
    logic          outstanding;     // One read granted, response pending
    logic          stale;           // Pending response belongs to a cancelled stream
    logic          half_start;      // First word after redirect enters at bit 16
    logic          fetch_en;        // Holds off requests in the first cycle out of reset
    logic          req_go;
    logic          rsp_in;
    logic          rsp_live;

    assign flush    = cf_valid;
    assign flush_pc = cf_target;

    // Request dropped in the redirect cycle so the address never moves under it
    assign mem_req  = fetch_en && f_ready && !outstanding && !cf_valid;
    assign mem_addr = fetch_addr;

    assign req_go   = mem_req && mem_gnt;
    assign rsp_in   = mem_rvalid && outstanding;
    assign rsp_live = rsp_in && !stale && !cf_valid;    // Response kept

    assign f_4byte  = rsp_live && !half_start;
    assign f_2byte  = rsp_live && half_start;           // Upper halfword only
    assign f_err    = mem_err;
    assign f_in     = mem_rdata;

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            fetch_addr  <= {RESET_PC[XL-1:2], 2'b00};
            half_start  <= RESET_PC[1];
            outstanding <= 1'b0;
            stale       <= 1'b0;
            fetch_en    <= 1'b0;
        end else begin
            fetch_en <= 1'b1;

            if (req_go) begin
                outstanding <= 1'b1;
            end else if (rsp_in) begin
                outstanding <= 1'b0;
            end

            if (cf_valid) begin
                fetch_addr <= {cf_target[XL-1:2], 2'b00};
                half_start <= cf_target[1];
                // A response landing now is dropped here, later ones by stale
                stale      <= outstanding && !mem_rvalid;
            end else begin
                if (rsp_in) begin
                    stale <= 1'b0;
                end
                if (rsp_live) begin
                    fetch_addr <= fetch_addr + XL'(4);  // Next sequential word
                    half_start <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/frv_fetch_predecode.sv
`timescale 1ns/1ps
module frv_fetch_predecode #(
    parameter logic [frv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          flush,
    input  logic [frv_core_pkg::XLEN-1:0] flush_pc,
    input  logic [frv_core_pkg::XLEN-1:0] buf_out,
    input  logic                          buf_out_4,
    input  logic                          buf_valid,
    input  logic                          buf_err,
    input  logic                          instr_ready,
    output logic                          instr_valid,
    output logic [frv_core_pkg::XLEN-1:0] instr_data,
    output logic [frv_core_pkg::XLEN-1:0] instr_pc,
    output logic                          instr_size4,
    output logic                          instr_err,
    output logic                          instr_cf     // Branch or jump
);

    localparam int XL = frv_core_pkg::XLEN;
    localparam int HW = frv_core_pkg::HW_BITS;

    frv_instr_pkg::instr_word_t iw;
    logic [XL-1:0]              pc;         // PC of the shown instruction
    logic                       cf_32;
    logic                       cf_q1;
    logic                       cf_q2;

    assign iw          = buf_out;
    assign instr_valid = buf_valid;
    assign instr_size4 = buf_out_4;
    assign instr_err   = buf_err;
    assign instr_pc    = pc;
    assign instr_data  = buf_out_4 ? buf_out : {{(XL-HW){1'b0}}, buf_out[HW-1:0]};

    // Conditional branches, jal and jalr
    assign cf_32 = (iw.rv32.opcode == frv_instr_pkg::OPC_BRANCH) ||
                   (iw.rv32.opcode == frv_instr_pkg::OPC_JAL)    ||
                   (iw.rv32.opcode == frv_instr_pkg::OPC_JALR);

    // c.j, c.jal, c.beqz, c.bnez
    assign cf_q1 = (iw.rvc.quadrant == frv_instr_pkg::C_Q1) &&
                   ((iw.rvc.funct3 == frv_instr_pkg::C_J)    ||
                    (iw.rvc.funct3 == frv_instr_pkg::C_JAL)  ||
                    (iw.rvc.funct3 == frv_instr_pkg::C_BEQZ) ||
                    (iw.rvc.funct3 == frv_instr_pkg::C_BNEZ));

    // c.jr and c.jalr, rs2 sits in body[4:0]
    assign cf_q2 = (iw.rvc.quadrant == frv_instr_pkg::C_Q2)      &&
                   (iw.rvc.funct3 == frv_instr_pkg::C_JR_JALR)   &&
                   (iw.rvc.body[4:0] == 5'd0);

    assign instr_cf = buf_out_4 ? cf_32 : (cf_q1 || cf_q2);

    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= flush_pc;                     // New stream starts at the target
        end else if (instr_valid && instr_ready) begin
            pc <= pc + (instr_size4 ? XL'(4) : XL'(2));
        end
    end

endmodule

// File: design/frv_instr_pkg.sv
// Instruction encodings seen by the fetch predecoder
package frv_instr_pkg;

    // One fetched instruction word, read either as RV32 or as RVC
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;     // Low two bits are 2'b11 here
        } rv32;
        struct packed {
            logic [15:0] upper;     // Next parcel, not part of the instruction
            logic [2:0]  funct3;
            logic [10:0] body;      // Register fields and immediates
            logic [1:0]  quadrant;
        } rvc;
    } instr_word_t;

    // Full size control flow opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;

    // Compressed quadrants
    localparam logic [1:0] C_Q1       = 2'b01;
    localparam logic [1:0] C_Q2       = 2'b10;

    // Quadrant 1 funct3 codes
    localparam logic [2:0] C_JAL      = 3'b001;
    localparam logic [2:0] C_J        = 3'b101;
    localparam logic [2:0] C_BEQZ     = 3'b110;
    localparam logic [2:0] C_BNEZ     = 3'b111;

    // Quadrant 2, c.jr and c.jalr when rs2 is zero
    localparam logic [2:0] C_JR_JALR  = 3'b100;

endpackage

// File: frv_core_fetch.f
design/frv_core_pkg.sv
design/frv_instr_pkg.sv
design/frv_fetch_ctrl.sv
design/frv_core_fetch_buffer.sv
design/frv_fetch_predecode.sv
design/frv_core_fetch.sv
testbench/frv_fetch_checker.sv
testbench/frv_fetch_tb.sv

// File: testbench/frv_fetch_checker.sv
`timescale 1ns/1ps
module frv_fetch_checker #(
    parameter int MAX_DEPTH = 0     // Halfword slots of the buffer
) (
    input logic                          g_clk,
    input logic                          g_resetn,
    input logic [7:0]                    depth,
    input logic                          mem_req,
    input logic                          mem_gnt,
    input logic [frv_core_pkg::XLEN-1:0] mem_addr,
    input logic                          mem_rvalid
);

    int   assert_fails = 0;
    logic rd_open;                  // Read granted on the bus, response not seen yet

    // Bus side view of the single read in flight
    always_ff @(posedge g_clk) begin
        if (g_resetn) begin
            rd_open <= 1'b0;
        end else if (mem_req && mem_gnt) begin
            rd_open <= 1'b1;
        end else if (mem_rvalid) begin
            rd_open <= 1'b0;
        end
    end

    depth_bound: assert property (@(posedge g_clk) disable iff (g_resetn)
        depth <= 8'(MAX_DEPTH))
        else begin
            $error("buffer depth %0d above %0d halfwords", depth, MAX_DEPTH);
            assert_fails++;
        end

    // Address held until the grant
    addr_stable: assert property (@(posedge g_clk) disable iff (g_resetn)
        mem_req && !mem_gnt |=> $stable(mem_addr))
        else begin
            $error("mem_addr moved while the request waited for a grant");
            assert_fails++;
        end

    single_read: assert property (@(posedge g_clk) disable iff (g_resetn)
        rd_open |-> !mem_req)
        else begin
            $error("mem_req raised with a read outstanding");
            assert_fails++;
        end

endmodule

bind frv_core_fetch_buffer frv_fetch_checker #(
    .MAX_DEPTH (BWIDTH / 16)
) buf_chk (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .depth       (8'(bdepth)),
    .mem_req     (1'b0),
    .mem_gnt     (1'b0),
    .mem_addr    ('0),
    .mem_rvalid  (1'b0)
);

bind frv_fetch_ctrl frv_fetch_checker #(
    .MAX_DEPTH (0)
) ctrl_chk (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .depth       (8'd0),
    .mem_req     (mem_req),
    .mem_gnt     (mem_gnt),
    .mem_addr    (mem_addr),
    .mem_rvalid  (mem_rvalid)
);

// File: testbench/frv_fetch_tb.sv
`timescale 1ns/1ps
module frv_fetch_tb;

    localparam int            XL       = frv_core_pkg::XLEN;
    localparam logic [XL-1:0] RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic          cf;
        logic          err;
        logic          size4;
        logic [XL-1:0] data;
    } expect_t;

    logic          g_clk;
    logic          g_resetn;
    logic          cf_valid;
    logic [XL-1:0] cf_target;
    logic          mem_req;
    logic [XL-1:0] mem_addr;
    logic          mem_gnt;
    logic          mem_rvalid;
    logic [XL-1:0] mem_rdata;
    logic          mem_err;
    logic          instr_valid;
    logic [XL-1:0] instr_data;
    logic [XL-1:0] instr_pc;
    logic          instr_size4;
    logic          instr_err;
    logic          instr_cf;
    logic          instr_ready;

    logic [15:0]   image_hw [0:511];    // 1 KiB image, addresses wrap
    logic [31:0]   lfsr;
    int            error_count;
    int            n_checked;           // Instructions taken and compared
    logic [XL-1:0] exp_pc;
    expect_t       exp_rec;
    logic          random_ready;        // Back-pressure on
    int            ready_run;           // Cycles left at the current ready level
    logic          rsp_pending;         // Memory owes one response
    logic [1:0]    rsp_cnt;
    logic [1:0]    gnt_cnt;
    logic [XL-1:0] rsp_addr;
    logic          nxt_gnt;
    logic          nxt_rvalid;
    logic          held;                // Output was stalled last cycle

    frv_core_fetch #(
        .BWIDTH   (80),
        .RESET_PC (RESET_PC)
    ) uut (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .cf_valid    (cf_valid),
        .cf_target   (cf_target),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_gnt     (mem_gnt),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_err     (mem_err),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_pc    (instr_pc),
        .instr_size4 (instr_size4),
        .instr_err   (instr_err),
        .instr_cf    (instr_cf),
        .instr_ready (instr_ready)
    );

    always #50 g_clk = ~g_clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};      // One step per bit
        end
        return v;
    endfunction

    // Words 0x40 to 0x5f answer with a bus error
    function automatic logic in_err_range(input logic [XL-1:0] a);
        return (a[9:2] >= 8'd16) && (a[9:2] < 8'd24);
    endfunction

    function automatic void build_image();
        logic [15:0] hw;
        logic [2:0]  kind;
        for (int i = 0; i < 512; i++) begin
            hw   = 16'(take_bits(16));
            kind = 3'(take_bits(3));
            case (kind)
                3'd0:    hw[6:0] = 7'b110_0011;            // Conditional branch
                3'd1:    hw[6:0] = 7'b110_1111;            // jal
                3'd2: begin
                    hw[15:13] = 3'b101;                     // c.j
                    hw[1:0]   = 2'b01;
                end
                3'd3: begin
                    hw[15:13] = 3'b100;                     // c.jr, rs2 zero
                    hw[6:0]   = 7'b000_0010;
                end
                3'd4,
                3'd5:    hw[1:0] = 2'b11;                  // Other 32-bit opcodes
                default: hw[1]   = hw[1] & ~hw[0];         // Any compressed quadrant
            endcase
            image_hw[i] = hw;
        end
    endfunction

    // Expected instruction at pc, straight from the image
    function automatic expect_t ref_instr(input logic [XL-1:0] pc);
        logic [8:0]  idx;
        logic [15:0] lo;
        logic [15:0] hi;
        expect_t     e;
        idx     = pc[9:1];
        lo      = image_hw[idx];
        hi      = image_hw[idx + 9'd1];
        e.size4 = lo[1:0] == 2'b11;
        e.data  = e.size4 ? {hi, lo} : {16'h0000, lo};
        e.err   = in_err_range(pc) || (e.size4 && in_err_range(pc + 32'd2));
        if (e.size4) begin
            e.cf = lo[6:0] inside {7'b110_0011, 7'b110_1111, 7'b110_0111};
        end else begin
            e.cf = ((lo[1:0] == 2'b01) && (lo[15:13] inside {3'b001, 3'b101, 3'b110, 3'b111}))
                || ((lo[1:0] == 2'b10) && (lo[15:13] == 3'b100) && (lo[6:2] == 5'd0));
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [XL-1:0] got,
                               input logic [XL-1:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout while waiting for %s", what);
        error_count++;
    endtask

    // Memory model, decides next cycle from settled values
    always @(negedge g_clk) begin
        nxt_gnt    = 1'b0;
        nxt_rvalid = 1'b0;
        if (g_resetn) begin
            rsp_pending = 1'b0;
        end else begin
            if (mem_rvalid) begin
                rsp_pending = 1'b0;                         // Delivered this cycle
            end
            if (mem_req && mem_gnt) begin
                rsp_pending = 1'b1;
                rsp_addr    = mem_addr;
                rsp_cnt     = 2'(take_bits(2));             // Response delay
            end else if (mem_req) begin
                if (gnt_cnt == 2'd0) begin
                    nxt_gnt = 1'b1;
                    gnt_cnt = 2'(take_bits(2));             // Grant delay of the next one
                end else begin
                    gnt_cnt = gnt_cnt - 2'd1;
                end
            end
            if (rsp_pending) begin
                if (rsp_cnt == 2'd0) begin
                    nxt_rvalid = 1'b1;
                end else begin
                    rsp_cnt = rsp_cnt - 2'd1;
                end
            end
        end
    end

    always @(posedge g_clk) begin
        #1;
        mem_gnt    = nxt_gnt;
        mem_rvalid = nxt_rvalid;
        mem_rdata  = nxt_rvalid ? {image_hw[{rsp_addr[9:2], 1'b1}],
                                   image_hw[{rsp_addr[9:2], 1'b0}]} : '0;
        mem_err    = nxt_rvalid && in_err_range(rsp_addr);
        if (!random_ready) begin
            instr_ready = 1'b1;
        end else if (ready_run > 0) begin
            ready_run--;
        end else begin
            instr_ready = 1'(take_bits(1));                 // New level for a short run
            ready_run   = int'(take_bits(2));
        end
    end

    // Compare every shown instruction against the image
    always @(negedge g_clk) begin
        if (g_resetn) begin
            exp_pc = RESET_PC;
            held   = 1'b0;
        end else begin
            if (held) begin                                 // Stalled output must stay
                check_value("instr_valid", XL'(instr_valid), XL'(1));
            end
            if (instr_valid) begin                          // Stalled cycles show the same one
                exp_rec = ref_instr(exp_pc);
                check_value("instr_pc", instr_pc, exp_pc);
                check_value("instr_data", instr_data, exp_rec.data);
                check_value("instr_size4", XL'(instr_size4), XL'(exp_rec.size4));
                check_value("instr_err", XL'(instr_err), XL'(exp_rec.err));
                check_value("instr_cf", XL'(instr_cf), XL'(exp_rec.cf));
                if (instr_ready) begin
                    exp_pc = exp_pc + (exp_rec.size4 ? 32'd4 : 32'd2);
                    n_checked++;
                end
            end
            held = instr_valid && !instr_ready && !cf_valid;
            if (cf_valid) begin
                exp_pc = cf_target;                         // New stream from here on
            end
        end
    end

    task automatic redirect(input logic [XL-1:0] target);
        @(posedge g_clk);
        #1;
        cf_valid  = 1'b1;
        cf_target = target;
        @(posedge g_clk);
        #1;
        cf_valid  = 1'b0;
    endtask

    task automatic wait_instrs(input int n, output logic ok);
        int target;
        int cycles;
        target = n_checked + n;
        cycles = 0;
        while (n_checked < target && cycles < 40 * n + 200) begin
            @(posedge g_clk);
            cycles++;
        end
        ok = n_checked >= target;
        if (!ok) begin
            timeout_error("instructions at the output");
        end
    endtask

    task automatic wait_pending(output logic ok);
        int cycles;
        cycles = 0;
        while (!rsp_pending && cycles < 200) begin
            @(posedge g_clk);
            cycles++;
        end
        ok = rsp_pending;
        if (!ok) begin
            timeout_error("a granted read");
        end
    endtask

    task automatic run_tests();
        logic ok;
        wait_instrs(64, ok);                                // Runs through the error words
        if (!ok) return;
        redirect(32'h0000_0100);                            // Word aligned
        wait_instrs(16, ok);
        if (!ok) return;
        redirect(32'h0000_02a6);                            // Halfword aligned
        wait_instrs(16, ok);
        if (!ok) return;
        redirect(32'h0000_003e);                            // Straddles the error range
        wait_instrs(16, ok);
        if (!ok) return;
        for (int i = 0; i < 6; i++) begin                   // Redirect with a read in flight
            wait_pending(ok);
            if (!ok) return;
            redirect(32'h0000_0200 + 32'(i * 34));
            wait_instrs(4, ok);
            if (!ok) return;
        end
        random_ready = 1'b1;
        wait_instrs(100, ok);
        if (!ok) return;
        redirect(32'h0000_0382);
        wait_instrs(100, ok);
        if (!ok) return;
        random_ready = 1'b0;
        wait_instrs(8, ok);
    endtask

    task automatic end_run();
        int assert_fails;
        assert_fails = uut.u_ctrl.ctrl_chk.assert_fails + uut.u_buffer.buf_chk.assert_fails;
        $display("Errors: %0d, assertion failures: %0d, instructions checked: %0d",
                 error_count, assert_fails, n_checked);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        g_clk        = 1'b0;
        g_resetn     = 1'b1;
        cf_valid     = 1'b0;
        cf_target    = '0;
        mem_gnt      = 1'b0;
        mem_rvalid   = 1'b0;
        mem_rdata    = '0;
        mem_err      = 1'b0;
        instr_ready  = 1'b1;
        lfsr         = 32'he72b_bb20;
        error_count  = 0;
        n_checked    = 0;
        random_ready = 1'b0;
        ready_run    = 0;
        rsp_pending  = 1'b0;
        rsp_cnt      = '0;
        gnt_cnt      = '0;
        rsp_addr     = '0;
        nxt_gnt      = 1'b0;
        nxt_rvalid   = 1'b0;
        held         = 1'b0;
        exp_pc       = RESET_PC;
        build_image();
        repeat (5) @(posedge g_clk);
        #1;
        g_resetn = 1'b0;
        run_tests();
        end_run();
    end

endmodule
